// ==== cpu_alu.sv ====
`timescale 1ns/1ns

module cpu_alu (
    input  logic [31:0]          a,
    input  logic [31:0]          b,
    input  cpu_isa_pkg::alu_op_e func,
    output logic [31:0]          result,
    output cpu_isa_pkg::ccr_t    flags
);

    logic [32:0] diff;

    assign diff = {1'b0, a} - {1'b0, b};   // borrow in bit 32

    always_comb begin
        case (func)
            cpu_isa_pkg::ALU_ADD:  result = a + b;
            cpu_isa_pkg::ALU_SUB:  result = diff[31:0];
            cpu_isa_pkg::ALU_AND:  result = a & b;
            cpu_isa_pkg::ALU_OR:   result = a | b;
            cpu_isa_pkg::ALU_XOR:  result = a ^ b;
            cpu_isa_pkg::ALU_SHL:  result = a << b[4:0];
            cpu_isa_pkg::ALU_SHR:  result = a >> b[4:0];
            cpu_isa_pkg::ALU_ASHR: result = $signed(a) >>> b[4:0];
            default:               result = a;
        endcase
    end

    assign flags.ltu = diff[32];
    // a is less when negative if the signs differ
    assign flags.lt  = (a[31] ^ b[31]) ? a[31] : diff[31];
    assign flags.eq  = (diff[31:0] == 32'h0);

endmodule

// ==== cpu_control.sv ====
`timescale 1ns/1ns

module cpu_control (
    input  logic                clk_i,
    input  logic                rst_i,
    input  cpu_isa_pkg::insn_u  ir,
    input  cpu_isa_pkg::ccr_t   ccr,
    input  logic                bus_ack,
    output cpu_ctrl_pkg::ctrl_t ctrl,
    output logic                bus_cyc,
    output logic                bus_write,
    output logic                halt
);

    typedef enum logic [4:0] {
        S_FETCH, S_FETCH2, S_EVAL, S_TERM, S_ARG, S_ARG2, S_INH,
        S_CMP, S_CMP2, S_CMP3, S_ALU, S_ALU2, S_ALU3, S_ALU4,
        S_MDR2RA, S_BRANCH, S_LDIU, S_LOAD, S_LOAD2, S_LOAD3, S_LOADD,
        S_STORE, S_STORE2, S_STORE3, S_STORED, S_STORED2, S_STORE4, S_HALT
    } state_e;

    state_e state, state_next;
    logic   take;

    assign halt = (state == S_HALT);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state <= S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    // branch condition table
    always_comb begin
        case (ir.r.op)
            cpu_isa_pkg::BR_BRA:  take = 1'b1;
            cpu_isa_pkg::BR_BEQ:  take = ccr.eq;
            cpu_isa_pkg::BR_BNE:  take = ~ccr.eq;
            cpu_isa_pkg::BR_BGTU: take = ~(ccr.ltu | ccr.eq);
            cpu_isa_pkg::BR_BGT:  take = ~(ccr.lt | ccr.eq);
            cpu_isa_pkg::BR_BGE:  take = ~ccr.lt;
            cpu_isa_pkg::BR_BLE:  take = ccr.lt | ccr.eq;
            cpu_isa_pkg::BR_BLT:  take = ccr.lt;
            cpu_isa_pkg::BR_BGEU: take = ~ccr.ltu;
            cpu_isa_pkg::BR_BLTU: take = ccr.ltu;
            cpu_isa_pkg::BR_BLEU: take = ccr.ltu | ccr.eq;
            default:              take = 1'b0;   // brn
        endcase
    end

    always_comb begin
        state_next          = state;
        ctrl                = '0;   // all selects hold, no writes
        ctrl.reg_read_addr1 = ir.r.ra;
        ctrl.reg_read_addr2 = ir.r.rb;
        ctrl.reg_write_addr = ir.r.ra;
        ctrl.alu_func       = cpu_isa_pkg::ALU_ADD;
        bus_cyc             = 1'b0;
        bus_write           = 1'b0;

        case (state)
            S_FETCH: begin
                bus_cyc       = 1'b1;
                ctrl.ir_write = 1'b1;
                if (bus_ack)
                    state_next = S_FETCH2;
            end
            S_FETCH2: begin
                ctrl.pc_sel = cpu_ctrl_pkg::PC_NEXT;
                state_next  = S_EVAL;
            end
            S_EVAL: begin
                case (ir.r.itype)
                    cpu_isa_pkg::T_INH:    state_next = S_INH;
                    cpu_isa_pkg::T_CMP:    state_next = S_CMP;
                    cpu_isa_pkg::T_ALU:    state_next = S_ALU;
                    cpu_isa_pkg::T_BRANCH: state_next = S_BRANCH;
                    cpu_isa_pkg::T_LDI:    state_next = ir.r.size ? S_ARG : S_LDIU;
                    cpu_isa_pkg::T_LOAD:   state_next = ir.r.size ? S_ARG : S_LOAD;
                    cpu_isa_pkg::T_STORE:  state_next = ir.r.size ? S_ARG : S_STORE;
                    default:               state_next = S_HALT;
                endcase
            end
            S_TERM: state_next = S_FETCH;
            S_ARG: begin   // second word into MAR and MDR
                bus_cyc      = 1'b1;
                ctrl.mar_sel = cpu_ctrl_pkg::MAR_BUS;
                ctrl.mdr_sel = cpu_ctrl_pkg::MDR_BUS;
                if (bus_ack)
                    state_next = S_ARG2;
            end
            S_ARG2: begin
                ctrl.pc_sel = cpu_ctrl_pkg::PC_NEXT;
                case (ir.r.itype)
                    cpu_isa_pkg::T_LOAD:  state_next = S_LOADD;
                    cpu_isa_pkg::T_STORE: state_next = S_STORED;
                    default:              state_next = S_MDR2RA;   // ldi with word
                endcase
            end
            S_INH: state_next = (ir.r.op == 4'h0) ? S_FETCH : S_HALT;
            S_CMP: begin
                ctrl.a_write = 1'b1;
                ctrl.b_write = 1'b1;
                state_next   = S_CMP2;
            end
            S_CMP2: begin
                ctrl.alu_func = cpu_isa_pkg::ALU_SUB;
                state_next    = S_CMP3;
            end
            S_CMP3: begin
                ctrl.alu_func = cpu_isa_pkg::ALU_SUB;
                ctrl.ccr_sel  = cpu_ctrl_pkg::CCR_ALU;
                state_next    = S_FETCH;
            end
            S_ALU: begin
                ctrl.reg_read_addr1 = ir.r.rb;
                ctrl.reg_read_addr2 = ir.r.rc;
                ctrl.a_write        = 1'b1;
                ctrl.b_write        = 1'b1;
                state_next          = ir.r.op[3] ? S_ALU3 : S_ALU2;
            end
            S_ALU2: begin
                ctrl.alu_func = cpu_isa_pkg::alu_op_e'(ir.r.op[2:0]);
                state_next    = S_ALU4;
            end
            S_ALU3: begin   // immediate form
                ctrl.alu_func = cpu_isa_pkg::alu_op_e'(ir.r.op[2:0]);
                ctrl.alu2_sel = cpu_ctrl_pkg::ALU2_SVAL;
                state_next    = S_ALU4;
            end
            S_ALU4: begin
                ctrl.mdr_sel = cpu_ctrl_pkg::MDR_ALU;
                state_next   = S_MDR2RA;
            end
            S_MDR2RA: begin
                ctrl.reg_sel   = cpu_ctrl_pkg::REG_MDR;
                ctrl.reg_write = 1'b1;
                state_next     = S_FETCH;
            end
            S_BRANCH: begin
                if (take)
                    ctrl.pc_sel = cpu_ctrl_pkg::PC_REL;
                state_next = S_FETCH;
            end
            S_LDIU: begin
                ctrl.reg_sel   = cpu_ctrl_pkg::REG_UVAL;
                ctrl.reg_write = 1'b1;
                state_next     = S_FETCH;
            end
            S_LOAD: begin
                ctrl.reg_read_addr1 = ir.r.rb;
                ctrl.a_write        = 1'b1;
                state_next          = S_LOAD2;
            end
            S_LOAD2: begin
                ctrl.alu2_sel = cpu_ctrl_pkg::ALU2_SVAL;
                state_next    = S_LOAD3;
            end
            S_LOAD3: begin
                ctrl.mar_sel = cpu_ctrl_pkg::MAR_ALU;
                state_next   = S_LOADD;
            end
            S_LOADD: begin
                bus_cyc       = 1'b1;
                ctrl.addr_sel = cpu_ctrl_pkg::ADDR_MAR;
                ctrl.mdr_sel  = cpu_ctrl_pkg::MDR_BUS;
                if (bus_ack)
                    state_next = S_MDR2RA;
            end
            S_STORE: begin
                ctrl.reg_read_addr1 = ir.r.rb;
                ctrl.a_write        = 1'b1;
                state_next          = S_STORE2;
            end
            S_STORE2: begin   // address in ALU, rA into A
                ctrl.alu2_sel = cpu_ctrl_pkg::ALU2_SVAL;
                ctrl.a_write  = 1'b1;
                state_next    = S_STORE3;
            end
            S_STORE3: begin
                ctrl.mar_sel = cpu_ctrl_pkg::MAR_ALU;
                ctrl.mdr_sel = cpu_ctrl_pkg::MDR_A;
                state_next   = S_STORE4;
            end
            S_STORED: begin
                ctrl.a_write = 1'b1;
                state_next   = S_STORED2;
            end
            S_STORED2: begin
                ctrl.mdr_sel = cpu_ctrl_pkg::MDR_A;
                state_next   = S_STORE4;
            end
            S_STORE4: begin
                bus_cyc       = 1'b1;
                bus_write     = 1'b1;
                ctrl.addr_sel = cpu_ctrl_pkg::ADDR_MAR;
                if (bus_ack)
                    state_next = S_TERM;
            end
            default: state_next = S_HALT;   // stuck until reset
        endcase
    end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu_core (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic [`CPU_WORD_W-1:0] bus_rdata,
    input  logic                   bus_ack,
    output cpu_ctrl_pkg::bus_req_t bus_req,
    output logic                   halt
);

    cpu_ctrl_pkg::ctrl_t    ctrl;
    cpu_isa_pkg::insn_u     ir;
    cpu_isa_pkg::ccr_t      ccr;
    logic                   bus_cyc;
    logic                   bus_write;
    logic [`CPU_WORD_W-1:0] bus_adr;
    logic [`CPU_WORD_W-1:0] bus_wdata;

    cpu_control u_control (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .ir        (ir),
        .ccr       (ccr),
        .bus_ack   (bus_ack),
        .ctrl      (ctrl),
        .bus_cyc   (bus_cyc),
        .bus_write (bus_write),
        .halt      (halt)
    );

    cpu_datapath u_datapath (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .ctrl      (ctrl),
        .bus_rdata (bus_rdata),
        .ir        (ir),
        .ccr       (ccr),
        .bus_adr   (bus_adr),
        .bus_wdata (bus_wdata)
    );

    assign bus_req = '{cyc: bus_cyc, write: bus_write, adr: bus_adr, dat: bus_wdata};

endmodule

// ==== cpu_core_sva.sv ====
`timescale 1ns/1ns

module cpu_core_sva (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   bus_ack,
    input cpu_ctrl_pkg::bus_req_t bus_req,
    input logic                   halt
);

    // an open cycle keeps its request until acked
    property p_req_hold;
        @(posedge clk_i) disable iff (rst_i)
        (bus_req.cyc && !bus_ack) |=>
            (bus_req.cyc && $stable(bus_req.adr) && $stable(bus_req.write) &&
             (!bus_req.write || $stable(bus_req.dat)));
    endproperty

    property p_write_in_cyc;
        @(posedge clk_i) disable iff (rst_i)
        bus_req.write |-> bus_req.cyc;
    endproperty

    // halt is sticky and the bus stays idle
    property p_quiet_after_halt;
        @(posedge clk_i) disable iff (rst_i)
        halt |=> (halt && !bus_req.cyc);
    endproperty

    a_req_hold: assert property (p_req_hold)
        else $error("bus request changed while waiting for ack");
    a_write_in_cyc: assert property (p_write_in_cyc)
        else $error("bus write high without cycle");
    a_quiet_after_halt: assert property (p_quiet_after_halt)
        else $error("bus cycle after halt");

endmodule

bind cpu_core cpu_core_sva u_sva (.*);

// ==== cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    typedef enum logic [1:0] {
        ALU2_B,
        ALU2_4,
        ALU2_SVAL
    } alu2_sel_e;

    typedef enum logic [1:0] {
        REG_ALU,
        REG_MDR,
        REG_B,
        REG_UVAL
    } reg_sel_e;

    typedef enum logic [1:0] {
        MDR_HOLD,
        MDR_BUS,
        MDR_ALU,
        MDR_A
    } mdr_sel_e;

    typedef enum logic [1:0] {
        MAR_HOLD,
        MAR_ALU,
        MAR_BUS
    } mar_sel_e;

    typedef enum logic [1:0] {
        PC_HOLD,
        PC_NEXT,
        PC_REL,
        PC_MAR
    } pc_sel_e;

    typedef enum logic {
        CCR_HOLD,
        CCR_ALU
    } ccr_sel_e;

    typedef enum logic {
        ADDR_PC,
        ADDR_MAR
    } addr_sel_e;

    typedef struct packed {
        logic                 ir_write;
        logic                 a_write;
        logic                 b_write;
        logic                 reg_write;
        logic [3:0]           reg_read_addr1;
        logic [3:0]           reg_read_addr2;
        logic [3:0]           reg_write_addr;
        cpu_isa_pkg::alu_op_e alu_func;
        alu2_sel_e            alu2_sel;
        reg_sel_e             reg_sel;
        mdr_sel_e             mdr_sel;
        mar_sel_e             mar_sel;
        pc_sel_e              pc_sel;
        ccr_sel_e             ccr_sel;
        addr_sel_e            addr_sel;
    } ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        write;
        logic [31:0] adr;
        logic [31:0] dat;
    } bus_req_t;

endpackage

// ==== cpu_datapath.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu_datapath (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  cpu_ctrl_pkg::ctrl_t    ctrl,
    input  logic [`CPU_WORD_W-1:0] bus_rdata,
    output cpu_isa_pkg::insn_u     ir,
    output cpu_isa_pkg::ccr_t      ccr,
    output logic [`CPU_WORD_W-1:0] bus_adr,
    output logic [`CPU_WORD_W-1:0] bus_wdata
);

    logic [`CPU_WORD_W-1:0] pc, mar, mdr, a, b, alu_q;
    logic [`CPU_WORD_W-1:0] rd1, rd2, alu2, alu_res, reg_wdata;
    logic [`CPU_WORD_W-1:0] sval, uval;
    cpu_isa_pkg::ccr_t      alu_flags;

    assign sval = {{(`CPU_WORD_W-15){ir.i.value[14]}}, ir.i.value};
    assign uval = {{(`CPU_WORD_W-15){1'b0}}, ir.i.value};

    assign bus_adr   = (ctrl.addr_sel == cpu_ctrl_pkg::ADDR_MAR) ? mar : pc;
    assign bus_wdata = mdr;

    always_comb begin
        case (ctrl.alu2_sel)
            cpu_ctrl_pkg::ALU2_4:    alu2 = `CPU_WORD_W'(4);
            cpu_ctrl_pkg::ALU2_SVAL: alu2 = sval;
            default:                 alu2 = b;
        endcase
    end

    always_comb begin
        case (ctrl.reg_sel)
            cpu_ctrl_pkg::REG_MDR:  reg_wdata = mdr;
            cpu_ctrl_pkg::REG_B:    reg_wdata = b;
            cpu_ctrl_pkg::REG_UVAL: reg_wdata = uval;
            default:                reg_wdata = alu_q;
        endcase
    end

    cpu_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .read_addr1 (ctrl.reg_read_addr1),
        .read_addr2 (ctrl.reg_read_addr2),
        .write_addr (ctrl.reg_write_addr),
        .write_en   (ctrl.reg_write),
        .write_data (reg_wdata),
        .read_data1 (rd1),
        .read_data2 (rd2)
    );

    cpu_alu u_alu (
        .a      (a),
        .b      (alu2),
        .func   (ctrl.alu_func),
        .result (alu_res),
        .flags  (alu_flags)
    );

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc  <= `CPU_RESET_PC;
            ccr <= '0;
        end else begin
            case (ctrl.pc_sel)
                cpu_ctrl_pkg::PC_NEXT: pc <= pc + `CPU_WORD_W'(4);
                cpu_ctrl_pkg::PC_REL:  pc <= pc + (sval << 2);   // word offset
                cpu_ctrl_pkg::PC_MAR:  pc <= mar;
                default:               pc <= pc;
            endcase
            if (ctrl.ccr_sel == cpu_ctrl_pkg::CCR_ALU)
                ccr <= alu_flags;
        end
    end

    always_ff @(posedge clk_i) begin
        alu_q <= alu_res;   // result used one state later
        if (ctrl.ir_write)
            ir <= bus_rdata;
        if (ctrl.a_write)
            a <= rd1;
        if (ctrl.b_write)
            b <= rd2;
        case (ctrl.mar_sel)
            cpu_ctrl_pkg::MAR_ALU: mar <= alu_q;
            cpu_ctrl_pkg::MAR_BUS: mar <= bus_rdata;
            default:               mar <= mar;
        endcase
        case (ctrl.mdr_sel)
            cpu_ctrl_pkg::MDR_BUS: mdr <= bus_rdata;
            cpu_ctrl_pkg::MDR_ALU: mdr <= alu_q;
            cpu_ctrl_pkg::MDR_A:   mdr <= a;
            default:               mdr <= mdr;
        endcase
    end

endmodule

// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    typedef enum logic [3:0] {
        T_INH    = 4'h0,
        T_CMP    = 4'h3,
        T_ALU    = 4'h9,
        T_LOAD   = 4'ha,
        T_STORE  = 4'hb,
        T_BRANCH = 4'hc,
        T_LDI    = 4'he
    } insn_type_e;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'h0,
        ALU_SUB  = 3'h1,
        ALU_AND  = 3'h2,
        ALU_OR   = 3'h3,
        ALU_XOR  = 3'h4,
        ALU_SHL  = 3'h5,
        ALU_SHR  = 3'h6,
        ALU_ASHR = 3'h7
    } alu_op_e;

    // values above BR_BLEU act as brn
    typedef enum logic [3:0] {
        BR_BRA  = 4'h0,
        BR_BEQ  = 4'h1,
        BR_BNE  = 4'h2,
        BR_BGTU = 4'h3,
        BR_BGT  = 4'h4,
        BR_BGE  = 4'h5,
        BR_BLE  = 4'h6,
        BR_BLT  = 4'h7,
        BR_BGEU = 4'h8,
        BR_BLTU = 4'h9,
        BR_BLEU = 4'ha
    } br_cond_e;

    typedef struct packed {
        logic ltu;
        logic lt;
        logic eq;
    } ccr_t;

    typedef struct packed {
        insn_type_e  itype;
        logic [3:0]  op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic [10:0] unused;
        logic        size;
    } insn_reg_t;

    typedef struct packed {
        insn_type_e  itype;
        logic [3:0]  op;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [14:0] value;
        logic        size;   // second word follows
    } insn_imm_t;

    typedef union packed {
        insn_reg_t r;
        insn_imm_t i;
    } insn_u;

endpackage

// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and address width
`define CPU_WORD_W 32

// register file size
`define CPU_REG_N 16

// r15 is the stack pointer by convention
`define CPU_REG_SP 15

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== cpu_regfile.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu_regfile (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic [$clog2(`CPU_REG_N)-1:0] read_addr1,
    input  logic [$clog2(`CPU_REG_N)-1:0] read_addr2,
    input  logic [$clog2(`CPU_REG_N)-1:0] write_addr,
    input  logic                          write_en,
    input  logic [`CPU_WORD_W-1:0]        write_data,
    output logic [`CPU_WORD_W-1:0]        read_data1,
    output logic [`CPU_WORD_W-1:0]        read_data2
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_REG_N];

    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < `CPU_REG_N; i++)
                regs[i] <= '0;
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_cpu_core \
    -Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
exit 0

// ==== tb.f ====
+incdir+.
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
cpu_regfile.sv
cpu_alu.sv
cpu_control.sv
cpu_datapath.sv
cpu_core.sv
cpu_core_sva.sv
tb_cpu_core.sv

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ns
`include "cpu_params.svh"

module tb_cpu_core;

    localparam int NPROG   = 80;
    localparam int MAXW    = 16;
    localparam int MAXS    = 4;
    localparam int TIMEOUT = 2000;

    logic                   clk_i;
    logic                   rst_i;
    logic                   bus_ack   = 1'b0;
    logic [`CPU_WORD_W-1:0] bus_rdata = '0;
    cpu_ctrl_pkg::bus_req_t bus_req;
    logic                   halt;

    logic [31:0] mem [256];
    logic [31:0] lcg_state = 32'd64789;
    logic [31:0] rnd;
    logic        busy;
    logic        wr_done;
    int          delay_cnt;

    cpu_ctrl_pkg::bus_req_t req_s;
    cpu_ctrl_pkg::bus_req_t store_q [$];

    // program table
    logic [31:0] prog_word [NPROG][MAXW];
    int          prog_len  [NPROG];
    logic [31:0] exp_adr   [NPROG][MAXS];
    logic [31:0] exp_dat   [NPROG][MAXS];
    int          exp_n     [NPROG];
    int          np;

    cpu_core uut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_rdata (bus_rdata),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req),
        .halt      (halt)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_i(logic [3:0] t, logic [3:0] op, logic [3:0] ra,
                                          logic [3:0] rb, logic [14:0] v, logic sz);
        return {t, op, ra, rb, v, sz};
    endfunction

    function automatic logic [31:0] enc_r(logic [3:0] t, logic [3:0] op, logic [3:0] ra,
                                          logic [3:0] rb, logic [3:0] rc);
        return {t, op, ra, rb, rc, 11'b0, 1'b0};
    endfunction

    function automatic logic [31:0] alu_expect(int op, logic [31:0] x, logic [31:0] y);
        case (op)
            0:       return x + y;
            1:       return x - y;
            2:       return x & y;
            3:       return x | y;
            4:       return x ^ y;
            5:       return x << y[4:0];
            6:       return x >> y[4:0];
            default: return $signed(x) >>> y[4:0];
        endcase
    endfunction

    function automatic logic cond_taken(int c, logic [31:0] x, logic [31:0] y);
        case (c)
            0:       return 1'b1;
            1:       return x == y;
            2:       return x != y;
            3:       return x > y;
            4:       return $signed(x) > $signed(y);
            5:       return $signed(x) >= $signed(y);
            6:       return $signed(x) <= $signed(y);
            7:       return $signed(x) < $signed(y);
            8:       return x >= y;
            9:       return x < y;
            10:      return x <= y;
            default: return 1'b0;   // brn
        endcase
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
            fail_stop($sformatf("error %0t ns: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_req(input string name, input cpu_ctrl_pkg::bus_req_t got,
                             input cpu_ctrl_pkg::bus_req_t exp);
        check_word({name, ".cyc"}, {31'b0, got.cyc}, {31'b0, exp.cyc});
        check_word({name, ".write"}, {31'b0, got.write}, {31'b0, exp.write});
        check_word({name, ".adr"}, got.adr, exp.adr);
        check_word({name, ".dat"}, got.dat, exp.dat);
    endtask

    task automatic emit(input logic [31:0] w);
        prog_word[np][prog_len[np]] = w;
        prog_len[np]++;
    endtask

    task automatic expect_store(input logic [31:0] adr, input logic [31:0] dat);
        exp_adr[np][exp_n[np]] = adr;
        exp_dat[np][exp_n[np]] = dat;
        exp_n[np]++;
    endtask

    task automatic prog_end();
        emit(32'hf000_0000);   // unknown type
        np++;
    endtask

    // r<ra> = 32-bit word via the two-word ldi
    task automatic emit_ldi32(input logic [3:0] ra, input logic [31:0] v);
        emit(enc_i(cpu_isa_pkg::T_LDI, 4'h0, ra, 4'h0, 15'h0, 1'b1));
        emit(v);
    endtask

    task automatic build_table();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] t;
        logic [31:0] xs [5];
        logic [31:0] ys [5];
        np = 0;
        for (int p = 0; p < NPROG; p++) begin
            prog_len[p] = 0;
            exp_n[p]    = 0;
        end
        // ldiu with base plus offset stores
        emit(enc_i(cpu_isa_pkg::T_LDI, 4'h0, 4'h1, 4'h0, 15'h1234, 1'b0));
        emit(enc_i(cpu_isa_pkg::T_LDI, 4'h0, 4'h2, 4'h0, 15'h0100, 1'b0));
        emit(32'h0000_0000);   // nop
        emit(enc_i(cpu_isa_pkg::T_LDI, 4'h0, 4'h3, 4'h0, 15'h7fff, 1'b0));
        emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h1, 4'h2, 15'h0008, 1'b0));
        emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h3, 4'h2, 15'h7ffc, 1'b0));
        expect_store(32'h108, 32'h1234);
        expect_store(32'h0fc, 32'h7fff);
        prog_end();
        // ALU register and immediate forms
        for (int op = 0; op < 8; op++) begin
            x = next_rand();
            y = next_rand();
            t = next_rand();
            emit_ldi32(4'h1, x);
            emit_ldi32(4'h2, y);
            emit(enc_r(cpu_isa_pkg::T_ALU, 4'(op), 4'h3, 4'h1, 4'h2));
            emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h3, 4'h0, 15'h0200, 1'b0));
            emit(enc_i(cpu_isa_pkg::T_ALU, 4'(8 + op), 4'h4, 4'h1, t[14:0], 1'b0));
            emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h4, 4'h0, 15'h0204, 1'b0));
            expect_store(32'h200, alu_expect(op, x, y));
            expect_store(32'h204, alu_expect(op, x, {{17{t[14]}}, t[14:0]}));
            prog_end();
        end
        // cmp then every branch condition
        xs[0] = 32'd5;
        ys[0] = 32'd5;
        xs[1] = 32'd3;
        ys[1] = 32'd9;
        xs[2] = 32'd9;
        ys[2] = 32'd3;
        xs[3] = 32'hffff_fff0;
        ys[3] = 32'd7;
        xs[4] = 32'd7;
        ys[4] = 32'h8000_0000;
        for (int k = 0; k < 5; k++) begin
            for (int c = 0; c < 13; c++) begin
                emit_ldi32(4'h1, xs[k]);
                emit_ldi32(4'h2, ys[k]);
                emit(enc_r(cpu_isa_pkg::T_CMP, 4'h0, 4'h1, 4'h2, 4'h0));
                emit(enc_i(cpu_isa_pkg::T_BRANCH, 4'(c), 4'h0, 4'h0, 15'h0001, 1'b0));
                emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h1, 4'h0, 15'h0300, 1'b0));
                emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h2, 4'h0, 15'h0304, 1'b0));
                if (!cond_taken(c, xs[k], ys[k]))
                    expect_store(32'h300, xs[k]);
                expect_store(32'h304, ys[k]);
                prog_end();
            end
        end
        // store, load back, store again; then absolute forms
        x = next_rand();
        emit_ldi32(4'h1, x);
        emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h1, 4'h0, 15'h0280, 1'b0));
        emit(enc_i(cpu_isa_pkg::T_LOAD, 4'h0, 4'h2, 4'h0, 15'h0280, 1'b0));
        emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h2, 4'h0, 15'h0284, 1'b0));
        emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h1, 4'h0, 15'h0, 1'b1));
        emit(32'h0000_02c0);
        emit(enc_i(cpu_isa_pkg::T_LOAD, 4'h0, 4'h3, 4'h0, 15'h0, 1'b1));
        emit(32'h0000_02c0);
        emit(enc_i(cpu_isa_pkg::T_STORE, 4'h0, 4'h3, 4'h0, 15'h0, 1'b1));
        emit(32'h0000_02c4);
        expect_store(32'h280, x);
        expect_store(32'h284, x);
        expect_store(32'h2c0, x);
        expect_store(32'h2c4, x);
        prog_end();
    endtask

    always @(negedge clk_i)
        req_s = bus_req;   // stable copy for the next edge

    // memory with random ack delay of 0 to 3 cycles
    always @(posedge clk_i) begin
        if (rst_i) begin
            bus_ack <= 1'b0;
            busy = 1'b0;
            wr_done = 1'b0;
        end else if (bus_ack) begin
            if (wr_done)
                store_q.push_back(req_s);   // request as held while acked
            bus_ack <= 1'b0;
            busy = 1'b0;
            wr_done = 1'b0;
        end else if (req_s.cyc) begin
            if (!busy) begin
                busy = 1'b1;
                rnd = next_rand();
                delay_cnt = int'(rnd[17:16]);
            end
            if (delay_cnt == 0) begin
                bus_ack <= 1'b1;
                if (req_s.write) begin
                    mem[req_s.adr[9:2]] = req_s.dat;
                    wr_done = 1'b1;
                end else begin
                    bus_rdata <= mem[req_s.adr[9:2]];
                end
            end else begin
                delay_cnt--;
            end
        end
    end

    task automatic run_program(input int p);
        cpu_ctrl_pkg::bus_req_t got;
        cpu_ctrl_pkg::bus_req_t exp;
        int cnt;
        @(posedge clk_i);
        rst_i <= 1'b1;
        store_q.delete();
        for (int i = 0; i < 256; i++)
            mem[i] = 32'hf000_0000 | 32'(i * 4);
        for (int i = 0; i < prog_len[p]; i++)
            mem[i] = prog_word[p][i];
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int s = 0; s < exp_n[p]; s++) begin
            cnt = 0;
            while (store_q.size() == 0) begin
                @(negedge clk_i);
                cnt++;
                if (cnt > TIMEOUT)
                    fail_stop($sformatf("timeout waiting for store %0d of program %0d", s, p));
            end
            got       = store_q.pop_front();
            exp.cyc   = 1'b1;
            exp.write = 1'b1;
            exp.adr   = exp_adr[p][s];
            exp.dat   = exp_dat[p][s];
            check_req("bus_req", got, exp);
            check_word("halt", {31'b0, halt}, 32'd0);
        end
        cnt = 0;
        while (halt !== 1'b1) begin
            @(negedge clk_i);
            cnt++;
            if (cnt > TIMEOUT)
                fail_stop($sformatf("timeout waiting for halt in program %0d", p));
        end
        check_word("extra stores", 32'(store_q.size()), 32'd0);
        repeat (20) begin
            @(negedge clk_i);
            check_word("bus_req.cyc", {31'b0, bus_req.cyc}, 32'd0);
        end
    endtask

    initial begin
        rst_i = 1'b1;
        build_table();
        for (int p = 0; p < np; p++)
            run_program(p);
        $display("Simulation passed");
        $finish;
    end

endmodule
